// ==== hdl/lsu_bus_geom_pkg.sv ====
`default_nettype none

// ************************************************************************
// bus geometry of the load/store unit
// ************************************************************************

package lsu_bus_geom_pkg;

   localparam int ADDR_W     = 32;  // byte address
   localparam int WORD_W     = 32;  // bus data word
   localparam int BYTE_LANES = 4;   // bytes per word
   localparam int WORD_OFS_W = 2;   // byte offset bits inside a word

   // address bit selecting the word inside a doubleword;
   // bits above it give the doubleword address
   localparam int DWORD_BIT  = 2;

endpackage : lsu_bus_geom_pkg

`default_nettype wire

// ==== hdl/lsu_bus_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsu_bus_top
   import lsu_bus_geom_pkg::*;
   import lsu_pipe_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   input  lsu_req_t          req_dc1,
   input  logic [WORD_W-1:0] bus_data_dc3,
   output logic [WORD_W-1:0] bus_read_data_dc3,
   output logic              ld_full_hit_dc3,
   output logic              no_word_merge_dc5,
   output logic              no_dword_merge_dc5
);

   lsu_stage_t stage_dc2;
   lsu_stage_t stage_dc3;
   lsu_stage_t stage_dc4;
   lsu_stage_t stage_dc5;
   lsu_fwd_t   fwd_dc3;
   lsu_fwd_t   fwd_dc4;
   lsu_fwd_t   fwd_dc5;

   // ************************************************************************
   // request pipe dc1 to dc5
   // ************************************************************************
   lsu_stage_pipe u_stage_pipe (
      .clk       (clk),
      .rst_n     (rst_n),
      .req_dc1   (req_dc1),
      .stage_dc2 (stage_dc2),
      .stage_dc3 (stage_dc3),
      .stage_dc4 (stage_dc4),
      .stage_dc5 (stage_dc5)
   );

   // ************************************************************************
   // store to load forwarding, dc2 load against dc3..dc5 stores
   // ************************************************************************
   lsu_fwd_match u_match_dc3 (
      .ld_stage (stage_dc2),
      .st_stage (stage_dc3),
      .fwd      (fwd_dc3)
   );

   lsu_fwd_match u_match_dc4 (
      .ld_stage (stage_dc2),
      .st_stage (stage_dc4),
      .fwd      (fwd_dc4)
   );

   lsu_fwd_match u_match_dc5 (
      .ld_stage (stage_dc2),
      .st_stage (stage_dc5),
      .fwd      (fwd_dc5)
   );

   lsu_fwd_merge u_fwd_merge (
      .clk               (clk),
      .rst_n             (rst_n),
      .ld_stage          (stage_dc2),
      .fwd_dc3           (fwd_dc3),
      .fwd_dc4           (fwd_dc4),
      .fwd_dc5           (fwd_dc5),
      .bus_data_dc3      (bus_data_dc3),
      .bus_read_data_dc3 (bus_read_data_dc3),
      .ld_full_hit_dc3   (ld_full_hit_dc3)
   );

   // write coalescing check for the dc5 store
   lsu_coalesce_chk u_coalesce_chk (
      .stage_dc2          (stage_dc2),
      .stage_dc3          (stage_dc3),
      .stage_dc4          (stage_dc4),
      .stage_dc5          (stage_dc5),
      .no_word_merge_dc5  (no_word_merge_dc5),
      .no_dword_merge_dc5 (no_dword_merge_dc5)
   );

endmodule : lsu_bus_top

`default_nettype wire

// ==== hdl/lsu_coalesce_chk.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsu_coalesce_chk
   import lsu_bus_geom_pkg::*;
   import lsu_pipe_pkg::*;
(
   input  lsu_stage_t stage_dc2,
   input  lsu_stage_t stage_dc3,
   input  lsu_stage_t stage_dc4,
   input  lsu_stage_t stage_dc5,
   output logic       no_word_merge_dc5,
   output logic       no_dword_merge_dc5
);

   logic       st_cand_dc5;      // single word store sitting in dc5
   lsu_stage_t younger;          // youngest valid request behind it
   logic       dw_match;
   logic       word_match;

   assign st_cand_dc5 = stage_dc5.valid & stage_dc5.store & ~stage_dc5.dual;

   // dc4 is the closest follower, dc2 the farthest
   always_comb begin
      if (stage_dc4.valid) begin
         younger = stage_dc4;
      end else if (stage_dc3.valid) begin
         younger = stage_dc3;
      end else begin
         younger = stage_dc2;     // valid bit still gates the result
      end
   end

   assign dw_match   = younger.addr[ADDR_W-1:DWORD_BIT+1] ==
                       stage_dc5.addr[ADDR_W-1:DWORD_BIT+1];
   assign word_match = dw_match & (younger.addr[DWORD_BIT] == stage_dc5.addr[DWORD_BIT]);

   // a load behind the store always breaks the merge
   assign no_word_merge_dc5  = st_cand_dc5 & younger.valid & (younger.load | ~word_match);
   assign no_dword_merge_dc5 = st_cand_dc5 & younger.valid & (younger.load | ~dw_match);

endmodule : lsu_coalesce_chk

`default_nettype wire

// ==== hdl/lsu_fwd_match.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsu_fwd_match
   import lsu_bus_geom_pkg::*;
   import lsu_pipe_pkg::*;
(
   input  lsu_stage_t ld_stage,   // dc2 request
   input  lsu_stage_t st_stage,   // one older stage
   output lsu_fwd_t   fwd
);

   logic                    qual;
   logic                    addr_hit_lo_lo;  // store start word vs load start word
   logic                    addr_hit_lo_hi;  // store start word vs load end word
   logic                    addr_hit_hi_lo;  // store end word vs load start word
   logic                    addr_hit_hi_hi;
   logic [2*BYTE_LANES-1:0] ld_byteen_ext;
   logic [2*BYTE_LANES-1:0] st_byteen_ext;
   logic [2*WORD_W-1:0]     st_data_ext;

   assign qual = st_stage.valid & st_stage.store & ld_stage.valid;

   assign addr_hit_lo_lo = qual & (ld_stage.addr[ADDR_W-1:WORD_OFS_W] ==
                                   st_stage.addr[ADDR_W-1:WORD_OFS_W]);
   assign addr_hit_lo_hi = qual & (ld_stage.end_addr[ADDR_W-1:WORD_OFS_W] ==
                                   st_stage.addr[ADDR_W-1:WORD_OFS_W]);
   assign addr_hit_hi_lo = qual & (ld_stage.addr[ADDR_W-1:WORD_OFS_W] ==
                                   st_stage.end_addr[ADDR_W-1:WORD_OFS_W]);
   assign addr_hit_hi_hi = qual & (ld_stage.end_addr[ADDR_W-1:WORD_OFS_W] ==
                                   st_stage.end_addr[ADDR_W-1:WORD_OFS_W]);

   // spread enables and store data over two words
   assign ld_byteen_ext = {{BYTE_LANES{1'b0}}, ld_stage.byteen} <<
                          ld_stage.addr[WORD_OFS_W-1:0];
   assign st_byteen_ext = {{BYTE_LANES{1'b0}}, st_stage.byteen} <<
                          st_stage.addr[WORD_OFS_W-1:0];
   assign st_data_ext   = {{WORD_W{1'b0}}, st_stage.store_data} <<
                          {st_stage.addr[WORD_OFS_W-1:0], 3'b000};

   // ************************************************************************
   // per byte hits and lane data
   // ************************************************************************
   always_comb begin
      logic [BYTE_LANES-1:0] st_lo;
      logic [BYTE_LANES-1:0] st_hi;
      logic [BYTE_LANES-1:0] ld_lo;
      logic [BYTE_LANES-1:0] ld_hi;
      st_lo = st_byteen_ext[BYTE_LANES-1:0];
      st_hi = st_byteen_ext[2*BYTE_LANES-1:BYTE_LANES];
      ld_lo = ld_byteen_ext[BYTE_LANES-1:0];
      ld_hi = ld_byteen_ext[2*BYTE_LANES-1:BYTE_LANES];
      fwd   = '0;
      for (int i = 0; i < BYTE_LANES; i++) begin
         // store lo lane wins only on its own word, lanes never overlap
         if (addr_hit_lo_lo && st_lo[i] && ld_lo[i]) begin
            fwd.hit_lo[i]        = 1'b1;
            fwd.data_lo[8*i +: 8] = st_data_ext[8*i +: 8];
         end else if (addr_hit_hi_lo && st_hi[i] && ld_lo[i]) begin
            fwd.hit_lo[i]        = 1'b1;
            fwd.data_lo[8*i +: 8] = st_data_ext[WORD_W + 8*i +: 8];
         end
         if (addr_hit_lo_hi && st_lo[i] && ld_hi[i]) begin
            fwd.hit_hi[i]        = 1'b1;
            fwd.data_hi[8*i +: 8] = st_data_ext[8*i +: 8];
         end else if (addr_hit_hi_hi && st_hi[i] && ld_hi[i]) begin
            fwd.hit_hi[i]        = 1'b1;
            fwd.data_hi[8*i +: 8] = st_data_ext[WORD_W + 8*i +: 8];
         end
      end
   end

endmodule : lsu_fwd_match

`default_nettype wire

// ==== hdl/lsu_fwd_merge.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsu_fwd_merge
   import lsu_bus_geom_pkg::*;
   import lsu_pipe_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   input  lsu_stage_t        ld_stage,           // dc2 request
   input  lsu_fwd_t          fwd_dc3,            // youngest store
   input  lsu_fwd_t          fwd_dc4,
   input  lsu_fwd_t          fwd_dc5,            // oldest store
   input  logic [WORD_W-1:0] bus_data_dc3,
   output logic [WORD_W-1:0] bus_read_data_dc3,
   output logic              ld_full_hit_dc3
);

   logic [2*BYTE_LANES-1:0] ld_byteen_ext;
   logic [BYTE_LANES-1:0]   ld_en_lo;
   logic [BYTE_LANES-1:0]   ld_en_hi;
   logic [BYTE_LANES-1:0]   hit_lo;
   logic [BYTE_LANES-1:0]   hit_hi;
   logic [WORD_W-1:0]       fwd_data_lo;
   logic [WORD_W-1:0]       fwd_data_hi;
   logic [2*WORD_W-1:0]     fwd_aligned_dc2;
   logic                    ld_full_hit_dc2;
   logic [WORD_W-1:0]       fwd_data_dc3;

   assign ld_byteen_ext = {{BYTE_LANES{1'b0}}, ld_stage.byteen} <<
                          ld_stage.addr[WORD_OFS_W-1:0];
   assign ld_en_lo      = ld_byteen_ext[BYTE_LANES-1:0];
   assign ld_en_hi      = ld_byteen_ext[2*BYTE_LANES-1:BYTE_LANES];

   // ************************************************************************
   // age merge, youngest hitting store supplies the byte
   // ************************************************************************
   always_comb begin
      for (int i = 0; i < BYTE_LANES; i++) begin
         hit_lo[i] = fwd_dc3.hit_lo[i] | fwd_dc4.hit_lo[i] | fwd_dc5.hit_lo[i];
         hit_hi[i] = fwd_dc3.hit_hi[i] | fwd_dc4.hit_hi[i] | fwd_dc5.hit_hi[i];

         if (fwd_dc3.hit_lo[i]) begin
            fwd_data_lo[8*i +: 8] = fwd_dc3.data_lo[8*i +: 8];
         end else if (fwd_dc4.hit_lo[i]) begin
            fwd_data_lo[8*i +: 8] = fwd_dc4.data_lo[8*i +: 8];
         end else begin
            fwd_data_lo[8*i +: 8] = fwd_dc5.data_lo[8*i +: 8];   // zero on a miss
         end

         if (fwd_dc3.hit_hi[i]) begin
            fwd_data_hi[8*i +: 8] = fwd_dc3.data_hi[8*i +: 8];
         end else if (fwd_dc4.hit_hi[i]) begin
            fwd_data_hi[8*i +: 8] = fwd_dc4.data_hi[8*i +: 8];
         end else begin
            fwd_data_hi[8*i +: 8] = fwd_dc5.data_hi[8*i +: 8];
         end
      end
   end

   // every enabled byte of both words must be covered
   assign ld_full_hit_dc2 = (&(hit_lo | ~ld_en_lo)) & (&(hit_hi | ~ld_en_hi)) &
                            ld_stage.valid & ld_stage.load & ~ld_stage.sideeffect;

   // first load byte down to lane 0
   assign fwd_aligned_dc2 = {fwd_data_hi, fwd_data_lo} >>
                            {ld_stage.addr[WORD_OFS_W-1:0], 3'b000};

   // ************************************************************************
   // dc3 register and return mux
   // ************************************************************************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ld_full_hit_dc3 <= 1'b0;
      end else begin
         ld_full_hit_dc3 <= ld_full_hit_dc2;
      end
   end

   always_ff @(posedge clk) begin
      fwd_data_dc3 <= fwd_aligned_dc2[WORD_W-1:0];
   end

   assign bus_read_data_dc3 = ld_full_hit_dc3 ? fwd_data_dc3 : bus_data_dc3;

endmodule : lsu_fwd_merge

`default_nettype wire

// ==== hdl/lsu_pipe_pkg.sv ====
`default_nettype none

package lsu_pipe_pkg;

   import lsu_bus_geom_pkg::*;

   // access size of a load or store
   typedef enum logic [1:0] {
      size_byte = 2'b00,
      size_half = 2'b01,
      size_word = 2'b10
   } lsu_size_e;

   // ************************************************************************
   // request as it enters the pipe at dc1
   // ************************************************************************
   typedef struct packed {
      logic              valid;
      logic              load;
      logic              store;
      lsu_size_e         size;
      logic              sideeffect;       // side-effect memory, never forwarded
      logic [ADDR_W-1:0] addr;
      logic [WORD_W-1:0] store_data;       // right aligned
   } lsu_req_t;

   // per-stage state, dc2 to dc5
   typedef struct packed {
      logic                  valid;
      logic                  load;
      logic                  store;
      logic                  sideeffect;
      logic [ADDR_W-1:0]     addr;
      logic [ADDR_W-1:0]     end_addr;     // last byte touched
      logic [BYTE_LANES-1:0] byteen;       // unshifted enables
      logic                  dual;         // access crosses into the next word
      logic [WORD_W-1:0]     store_data;
   } lsu_stage_t;

   // result of one older store compared against the dc2 load
   typedef struct packed {
      logic [BYTE_LANES-1:0] hit_lo;       // lanes of the load's first word
      logic [BYTE_LANES-1:0] hit_hi;       // lanes of the following word
      logic [WORD_W-1:0]     data_lo;
      logic [WORD_W-1:0]     data_hi;
   } lsu_fwd_t;

endpackage : lsu_pipe_pkg

`default_nettype wire

// ==== hdl/lsu_stage_pipe.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsu_stage_pipe
   import lsu_bus_geom_pkg::*;
   import lsu_pipe_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  lsu_req_t   req_dc1,
   output lsu_stage_t stage_dc2,
   output lsu_stage_t stage_dc3,
   output lsu_stage_t stage_dc4,
   output lsu_stage_t stage_dc5
);

   logic [BYTE_LANES-1:0] byteen_dc1;
   logic [WORD_OFS_W-1:0] size_m1_dc1;    // access size minus one
   logic [ADDR_W-1:0]     end_addr_dc1;
   lsu_stage_t            stage_dc1;
   lsu_stage_t            pipe_q [4];     // payload of dc2..dc5
   logic [3:0]            valid_q;        // bit 0 is dc2

   // ************************************************************************
   // dc1 decode
   // ************************************************************************
   always_comb begin
      case (req_dc1.size)
         size_half: begin
            byteen_dc1  = BYTE_LANES'(2'b11);
            size_m1_dc1 = WORD_OFS_W'(1);
         end
         size_word: begin
            byteen_dc1  = {BYTE_LANES{1'b1}};
            size_m1_dc1 = WORD_OFS_W'(BYTE_LANES - 1);
         end
         default: begin                   // byte
            byteen_dc1  = BYTE_LANES'(1'b1);
            size_m1_dc1 = '0;
         end
      endcase
   end

   assign end_addr_dc1 = req_dc1.addr + ADDR_W'(size_m1_dc1);

   always_comb begin
      stage_dc1.valid      = req_dc1.valid;
      stage_dc1.load       = req_dc1.load;
      stage_dc1.store      = req_dc1.store;
      stage_dc1.sideeffect = req_dc1.sideeffect;
      stage_dc1.addr       = req_dc1.addr;
      stage_dc1.end_addr   = end_addr_dc1;
      stage_dc1.byteen     = byteen_dc1;
      stage_dc1.dual       = req_dc1.addr[DWORD_BIT] != end_addr_dc1[DWORD_BIT];
      stage_dc1.store_data = req_dc1.store_data;
   end

   // ************************************************************************
   // stage registers, one step per clock
   // ************************************************************************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_q <= '0;
      end else begin
         valid_q <= {valid_q[2:0], req_dc1.valid};
      end
   end

   always_ff @(posedge clk) begin
      pipe_q[0] <= stage_dc1;
      pipe_q[1] <= pipe_q[0];
      pipe_q[2] <= pipe_q[1];
      pipe_q[3] <= pipe_q[2];
   end

   // valid comes from the reset flops, the rest from the payload
   always_comb begin
      stage_dc2       = pipe_q[0];
      stage_dc2.valid = valid_q[0];
      stage_dc3       = pipe_q[1];
      stage_dc3.valid = valid_q[1];
      stage_dc4       = pipe_q[2];
      stage_dc4.valid = valid_q[2];
      stage_dc5       = pipe_q[3];
      stage_dc5.valid = valid_q[3];
   end

endmodule : lsu_stage_pipe

`default_nettype wire

// ==== lsu_bus.f ====
+incdir+verification
hdl/lsu_bus_geom_pkg.sv
hdl/lsu_pipe_pkg.sv
hdl/lsu_stage_pipe.sv
hdl/lsu_fwd_match.sv
hdl/lsu_fwd_merge.sv
hdl/lsu_coalesce_chk.sv
hdl/lsu_bus_top.sv
verification/lsu_bus_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the lsu bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 \
      --top-module lsu_bus_tb -o lsu_bus_sim -f lsu_bus.f; then
   echo "verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/lsu_bus_sim 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"

if [ "$sim_status" -ne 0 ]; then
   echo "simulator exited with status $sim_status"
   exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Simulation completed successfully"; then
   echo "run passed"
   exit 0
fi

echo "pass message not found in simulator output"
exit 1

// ==== verification/lsu_bus_checks.svh ====
`ifndef LSU_BUS_CHECKS_SVH
`define LSU_BUS_CHECKS_SVH

// bytes touched by a request
function automatic int req_len(input lsu_req_t r);
   case (r.size)
      size_half: return 2;
      size_word: return 4;
      default:   return 1;
   endcase
endfunction

// true when store r writes byte address a
function automatic logic store_covers(input lsu_req_t r, input logic [ADDR_W-1:0] a);
   return r.valid && r.store && ((a - r.addr) < ADDR_W'(req_len(r)));
endfunction

// ************************************************************************
// expected dc3 result of a load against the three older stores
// ************************************************************************
function automatic void load_expect(input lsu_req_t ld, input lsu_req_t st_young,
                                    input lsu_req_t st_mid, input lsu_req_t st_old,
                                    output logic full, output logic [WORD_W-1:0] data);
   lsu_req_t          st [3];
   logic [ADDR_W-1:0] a;
   logic              covered;
   int                ofs;
   st[0] = st_young;
   st[1] = st_mid;
   st[2] = st_old;
   full  = ld.valid && ld.load && !ld.sideeffect;
   data  = '0;                                   // bytes above the load size stay zero
   for (int k = 0; k < req_len(ld); k++) begin
      a       = ld.addr + ADDR_W'(k);
      covered = 1'b0;
      for (int s = 0; s < 3 && !covered; s++) begin
         if (store_covers(st[s], a)) begin
            covered        = 1'b1;
            ofs            = int'(a - st[s].addr);
            data[8*k +: 8] = st[s].store_data[8*ofs +: 8];
         end
      end
      if (!covered) begin
         full = 1'b0;
      end
   end
endfunction

// {no_dword_merge, no_word_merge} for the dc5 store
function automatic logic [1:0] merge_expect(input lsu_req_t d5, input lsu_req_t d4,
                                            input lsu_req_t d3, input lsu_req_t d2);
   lsu_req_t          y;
   logic [ADDR_W-1:0] end_a;
   logic              cand;
   logic              other_word;
   logic              other_dword;
   end_a       = d5.addr + ADDR_W'(req_len(d5) - 1);
   cand        = d5.valid && d5.store && (d5.addr[DWORD_BIT] == end_a[DWORD_BIT]);
   y           = d4.valid ? d4 : (d3.valid ? d3 : d2);   // closest follower first
   other_word  = y.addr[ADDR_W-1:WORD_OFS_W] != d5.addr[ADDR_W-1:WORD_OFS_W];
   other_dword = y.addr[ADDR_W-1:DWORD_BIT+1] != d5.addr[ADDR_W-1:DWORD_BIT+1];
   if (!(cand && y.valid)) begin
      return 2'b00;
   end
   return {y.load || other_dword, y.load || other_word};
endfunction

task automatic report_value(input string what, input logic [WORD_W-1:0] expected,
                            input logic [WORD_W-1:0] actual);
   $display("FAILED %s %s: expected %h, actual %h", test_name, what, expected, actual);
   test_errors++;
endtask

// ************************************************************************
// output checks, one call per cycle
// ************************************************************************
task automatic check_outputs(input logic exp_hit, input logic [WORD_W-1:0] exp_data,
                             input logic [1:0] exp_flags);
   logic [WORD_W-1:0] exp_rd;
   exp_rd = exp_hit ? exp_data : bus_data_dc3;   // miss returns this cycle's bus word
   assert (ld_full_hit_dc3 === exp_hit)
      else report_value("ld_full_hit_dc3", WORD_W'(exp_hit), WORD_W'(ld_full_hit_dc3));
   assert (bus_read_data_dc3 === exp_rd)
      else report_value("bus_read_data_dc3", exp_rd, bus_read_data_dc3);
   assert (no_word_merge_dc5 === exp_flags[0])
      else report_value("no_word_merge_dc5", WORD_W'(exp_flags[0]),
                        WORD_W'(no_word_merge_dc5));
   assert (no_dword_merge_dc5 === exp_flags[1])
      else report_value("no_dword_merge_dc5", WORD_W'(exp_flags[1]),
                        WORD_W'(no_dword_merge_dc5));
endtask

`endif

// ==== verification/lsu_bus_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsu_bus_tb
   import lsu_bus_geom_pkg::*;
   import lsu_pipe_pkg::*;
();

   localparam int CLK_PERIOD   = 40;
   localparam int RESET_CYCLES = 16;
   localparam int N_DIRECTED   = 100;    // directed slots incl. drain, rounded up
   localparam int N_RANDOM     = 200;
   localparam int N_REQ        = N_DIRECTED + N_RANDOM + 4;
   localparam int TIMEOUT_NS   = 2 * (N_REQ * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD);

   logic              clk = 1'b0;
   logic              rst_n;
   lsu_req_t          req_dc1;
   logic [WORD_W-1:0] bus_data_dc3;
   logic [WORD_W-1:0] bus_read_data_dc3;
   logic              ld_full_hit_dc3;
   logic              no_word_merge_dc5;
   logic              no_dword_merge_dc5;

   integer            seed = 14;
   lsu_req_t          shadow [4];              // [0] is dc2 after the next edge
   logic              exp_hit_dc3  = 1'b0;
   logic [WORD_W-1:0] exp_data_dc3 = '0;
   string             test_name;
   int                test_errors;
   int                tests_passed = 0;
   int                tests_failed = 0;

   always #(CLK_PERIOD/2) clk = ~clk;

   lsu_bus_top u_lsu_bus_top (
      .clk                (clk),
      .rst_n              (rst_n),
      .req_dc1            (req_dc1),
      .bus_data_dc3       (bus_data_dc3),
      .bus_read_data_dc3  (bus_read_data_dc3),
      .ld_full_hit_dc3    (ld_full_hit_dc3),
      .no_word_merge_dc5  (no_word_merge_dc5),
      .no_dword_merge_dc5 (no_dword_merge_dc5)
   );

`include "lsu_bus_checks.svh"

   // ************************************************************************
   // stimulus helpers
   // ************************************************************************
   function automatic lsu_req_t make_req(input logic is_load, input logic [ADDR_W-1:0] addr,
                                         input lsu_size_e size, input logic [WORD_W-1:0] data,
                                         input logic se);
      lsu_req_t r;
      r            = '0;
      r.valid      = 1'b1;
      r.load       = is_load;
      r.store      = !is_load;
      r.size       = size;
      r.sideeffect = se;
      r.addr       = addr;
      r.store_data = is_load ? '0 : data;
      return r;
   endfunction

   function automatic lsu_size_e pick_size(input int v);
      case (v)
         0:       return size_byte;
         1:       return size_half;
         default: return size_word;
      endcase
   endfunction

   // check this cycle, then drive the next request on the falling edge
   task automatic clock_step(input lsu_req_t r);
      @(negedge clk);
      check_outputs(exp_hit_dc3, exp_data_dc3,
                    merge_expect(shadow[3], shadow[2], shadow[1], shadow[0]));
      load_expect(shadow[0], shadow[1], shadow[2], shadow[3], exp_hit_dc3, exp_data_dc3);
      shadow[3]    = shadow[2];
      shadow[2]    = shadow[1];
      shadow[1]    = shadow[0];
      shadow[0]    = r;
      req_dc1      = r;
      bus_data_dc3 = $random(seed);             // fresh bus word every cycle
   endtask

   task automatic issue_store(input logic [ADDR_W-1:0] addr, input lsu_size_e size,
                              input logic [WORD_W-1:0] data);
      clock_step(make_req(1'b0, addr, size, data, 1'b0));
   endtask

   task automatic issue_load(input logic [ADDR_W-1:0] addr, input lsu_size_e size,
                             input logic se);
      clock_step(make_req(1'b1, addr, size, '0, se));
   endtask

   task automatic idle_cycles(input int n);
      for (int i = 0; i < n; i++) begin
         clock_step('0);
      end
   endtask

   task automatic begin_test(input string name);
      test_name   = name;
      test_errors = 0;
   endtask

   task automatic end_test();
      idle_cycles(4);                            // let the last request reach dc5
      $display("test %s finished with %0d errors", test_name, test_errors);
      if (test_errors == 0) begin
         tests_passed++;
      end else begin
         tests_failed++;
      end
   endtask

   task automatic random_mix();
      lsu_req_t r;
      for (int n = 0; n < N_RANDOM; n++) begin
         r            = '0;
         r.valid      = ($random(seed) & 7) != 0;
         r.load       = ($random(seed) & 1) != 0;
         r.store      = !r.load;
         r.size       = pick_size($random(seed) & 3);
         r.sideeffect = r.load && (($random(seed) & 7) == 0);
         r.addr       = 32'h0000_0800 + ADDR_W'($random(seed) & 15);   // 16 byte window
         r.store_data = $random(seed);
         clock_step(r);
      end
   endtask

   // ************************************************************************
   // test sequence
   // ************************************************************************
   initial begin
      rst_n        = 1'b0;
      req_dc1      = '0;
      bus_data_dc3 = '0;
      foreach (shadow[i]) begin
         shadow[i] = '0;
      end
      repeat (RESET_CYCLES) @(negedge clk);
      rst_n = 1'b1;

      begin_test("reset_idle");
      idle_cycles(4);
      end_test();

      begin_test("fwd_distance");
      for (int d = 1; d <= 3; d++) begin
         issue_store(32'h100, size_word, 32'h1122_3340 + WORD_W'(d));
         idle_cycles(d - 1);
         issue_load(32'h100, size_word, 1'b0);
         idle_cycles(4);
      end
      end_test();

      begin_test("byte_merge");
      issue_store(32'h200, size_word, 32'hAAAA_AAAA);
      issue_store(32'h202, size_half, 32'h0000_BBBB);
      issue_store(32'h201, size_byte, 32'h0000_00CC);
      issue_load(32'h200, size_word, 1'b0);      // youngest byte per lane
      idle_cycles(4);
      issue_store(32'h300, size_half, 32'h0000_1234);
      issue_store(32'h302, size_byte, 32'h0000_0056);
      issue_load(32'h300, size_word, 1'b0);      // byte 3 uncovered
      idle_cycles(4);
      issue_store(32'h400, size_word, 32'hCAFE_F00D);
      issue_load(32'h400, size_word, 1'b1);      // side-effect load
      end_test();

      begin_test("straddle");
      issue_store(32'h500, size_word, 32'h4433_2211);
      issue_store(32'h504, size_word, 32'h8877_6655);
      issue_load(32'h502, size_word, 1'b0);
      issue_load(32'h503, size_half, 1'b0);
      end_test();

      begin_test("coalesce");
      issue_store(32'h600, size_word, 32'h0102_0304);
      issue_store(32'h601, size_byte, 32'h0000_0055);   // same word
      idle_cycles(4);
      issue_store(32'h600, size_word, 32'h0506_0708);
      issue_store(32'h604, size_word, 32'h090A_0B0C);   // other word, same dword
      idle_cycles(4);
      issue_store(32'h610, size_word, 32'h0D0E_0F10);
      issue_load(32'h610, size_word, 1'b0);
      idle_cycles(4);
      issue_store(32'h606, size_word, 32'h1112_1314);   // dual store
      issue_store(32'h700, size_word, 32'h1516_1718);
      idle_cycles(4);
      issue_store(32'h620, size_half, 32'h0000_1920);
      idle_cycles(2);
      issue_load(32'h640, size_byte, 1'b0);              // follower only in dc2
      end_test();

      begin_test("random_mix");
      random_mix();
      end_test();

      $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
      if (tests_failed == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   // watchdog
   initial begin
      #(TIMEOUT_NS);
      $display("watchdog expired, the tests did not finish in time");
      $display("Simulation failed");
      $finish;
   end

endmodule : lsu_bus_tb

`default_nettype wire
